// ==== verilog/rv_isa_pkg.sv ====
// RV32 instruction encodings
package rv_isa_pkg;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;

    localparam logic [6:0] F7_SUB = 7'b0100000;

    localparam logic [31:0] NOP_INSTR = 32'h0000_0013; // addi x0,x0,0.

    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic       imm12;
            logic [5:0] imm10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4_1;
            logic       imm11;
            logic [6:0] opcode;
        } b;
        struct packed {
            logic       imm20;
            logic [9:0] imm10_1;
            logic       imm11;
            logic [7:0] imm19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j;
    } rv_instr_u;

endpackage

// ==== verilog/rv_pipe_pkg.sv ====
// pipeline control encodings
package rv_pipe_pkg;

    localparam int ALU_OP_W = 3;

    localparam logic [ALU_OP_W-1:0] ALU_ADD    = 3'd0;
    localparam logic [ALU_OP_W-1:0] ALU_SUB    = 3'd1;
    localparam logic [ALU_OP_W-1:0] ALU_AND    = 3'd2;
    localparam logic [ALU_OP_W-1:0] ALU_OR     = 3'd3;
    localparam logic [ALU_OP_W-1:0] ALU_XOR    = 3'd4;
    localparam logic [ALU_OP_W-1:0] ALU_PASS_B = 3'd5; // lui result.

    // operand source for the execute stage
    localparam logic FWD_REG = 1'b0;
    localparam logic FWD_WB  = 1'b1;

    localparam logic [31:0] RESET_PC = 32'h0000_0000;

endpackage

// ==== verilog/fetch.sv ====
// instruction fetch stage
`timescale 1ns/1ps

module fetch
    import rv_pipe_pkg::*;
(
    input  logic        clk_i,
    input  logic        arst_n_i,
    input  logic        imem_wait_i,
    input  logic [31:0] imem_data_i,
    input  logic        redirect_valid_i,
    input  logic [31:0] redirect_pc_i,
    input  logic        flush_i,
    output logic        imem_cs_n_o,
    output logic [31:0] imem_addr_o,
    output logic        fd_valid_o,
    output logic [31:0] fd_instr_o,
    output logic [31:0] fd_pc_o
);

    logic [31:0] pc_q;
    logic        req_q;
    logic        accept;

    assign accept = req_q && !imem_wait_i; // word is valid this edge.

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q       <= RESET_PC;
            req_q      <= 1'b0;
            fd_valid_o <= 1'b0;
        end else begin
            req_q      <= 1'b1;
            fd_valid_o <= accept && !flush_i; // wrong-path word or wait gives a bubble.
            if (redirect_valid_i) begin
                pc_q <= redirect_pc_i; // replaces a pending address too.
            end else if (accept) begin
                pc_q <= pc_q + 32'd4;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            fd_instr_o <= imem_data_i;
            fd_pc_o    <= pc_q;
        end
    end

    assign imem_cs_n_o = !req_q;
    assign imem_addr_o = {pc_q[31:2], 2'b00};

endmodule

// ==== verilog/decode_regread.sv ====
// decode and register read stage
`timescale 1ns/1ps

module decode_regread
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
(
    input  logic                clk_i,
    input  logic                arst_n_i,
    input  logic                fd_valid_i,
    input  logic [31:0]         fd_instr_i,
    input  logic [31:0]         fd_pc_i,
    input  logic                flush_i,
    input  logic                wb_we_i,
    input  logic [4:0]          wb_rd_i,
    input  logic [31:0]         wb_data_i,
    output logic                de_valid_o,
    output logic [31:0]         de_pc_o,
    output logic [ALU_OP_W-1:0] de_alu_op_o,
    output logic [31:0]         de_op_a_o,
    output logic [31:0]         de_op_b_o,
    output logic [31:0]         de_imm_o,
    output logic [4:0]          de_rs1_o,
    output logic [4:0]          de_rs2_o,
    output logic [4:0]          de_rd_o,
    output logic                de_we_o,
    output logic                de_is_branch_o,
    output logic                de_branch_ne_o,
    output logic                de_is_jal_o,
    output logic                de_use_imm_o,
    output logic                de_illegal_o
);

    rv_instr_u           instr;
    logic [31:0]         regs [32];
    logic [ALU_OP_W-1:0] alu_op;
    logic [31:0]         imm;
    logic [31:0]         rdata_a;
    logic [31:0]         rdata_b;
    logic                we;
    logic                is_branch;
    logic                branch_ne;
    logic                is_jal;
    logic                use_imm;
    logic                illegal;
    logic                load_de;

    assign instr   = fd_instr_i;
    assign load_de = fd_valid_i && !flush_i;

    always_comb begin
        alu_op    = ALU_ADD;
        imm       = 32'd0;
        we        = 1'b0;
        is_branch = 1'b0;
        branch_ne = 1'b0;
        is_jal    = 1'b0;
        use_imm   = 1'b0;
        illegal   = 1'b0;
        case (instr.r.opcode)
            OPC_OP: begin
                we = 1'b1;
                if (instr.r.funct3 == F3_ADD_SUB && instr.r.funct7 == F7_SUB) alu_op = ALU_SUB;
                else if (instr.r.funct7 != 7'd0) illegal = 1'b1;
                else if (instr.r.funct3 == F3_XOR) alu_op = ALU_XOR;
                else if (instr.r.funct3 == F3_OR) alu_op = ALU_OR;
                else if (instr.r.funct3 == F3_AND) alu_op = ALU_AND;
                else if (instr.r.funct3 != F3_ADD_SUB) illegal = 1'b1;
            end
            OPC_OP_IMM: begin
                we      = 1'b1;
                use_imm = 1'b1;
                imm     = {{20{instr.i.imm[11]}}, instr.i.imm};
                illegal = (instr.i.funct3 != F3_ADD_SUB); // only addi.
            end
            OPC_LUI: begin
                we      = 1'b1;
                use_imm = 1'b1;
                alu_op  = ALU_PASS_B;
                imm     = {fd_instr_i[31:12], 12'd0};
            end
            OPC_BRANCH: begin
                is_branch = 1'b1;
                branch_ne = (instr.b.funct3 == F3_BNE);
                illegal   = (instr.b.funct3 != F3_BEQ) && (instr.b.funct3 != F3_BNE);
                imm = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                       instr.b.imm10_5, instr.b.imm4_1, 1'b0};
            end
            OPC_JAL: begin
                we     = 1'b1;
                is_jal = 1'b1;
                imm = {{11{instr.j.imm20}}, instr.j.imm20, instr.j.imm19_12,
                       instr.j.imm11, instr.j.imm10_1, 1'b0};
            end
            default: illegal = 1'b1;
        endcase
    end

    // x0 reads zero, a same-cycle write is passed through
    always_comb begin
        if (instr.r.rs1 == 5'd0) rdata_a = 32'd0;
        else if (wb_we_i && wb_rd_i == instr.r.rs1) rdata_a = wb_data_i;
        else rdata_a = regs[instr.r.rs1];
        if (instr.r.rs2 == 5'd0) rdata_b = 32'd0;
        else if (wb_we_i && wb_rd_i == instr.r.rs2) rdata_b = wb_data_i;
        else rdata_b = regs[instr.r.rs2];
    end

    always_ff @(posedge clk_i) begin
        if (wb_we_i && wb_rd_i != 5'd0) begin
            regs[wb_rd_i] <= wb_data_i;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            de_valid_o     <= 1'b0;
            de_we_o        <= 1'b0;
            de_is_branch_o <= 1'b0;
            de_is_jal_o    <= 1'b0;
            de_illegal_o   <= 1'b0;
        end else begin
            de_valid_o     <= load_de; // illegal words still retire.
            de_we_o        <= load_de && we && !illegal && instr.r.rd != 5'd0;
            de_is_branch_o <= load_de && is_branch && !illegal;
            de_is_jal_o    <= load_de && is_jal;
            de_illegal_o   <= load_de && illegal;
        end
    end

    always_ff @(posedge clk_i) begin
        de_pc_o        <= fd_pc_i;
        de_alu_op_o    <= alu_op;
        de_op_a_o      <= rdata_a;
        de_op_b_o      <= rdata_b;
        de_imm_o       <= imm;
        de_rs1_o       <= instr.r.rs1;
        de_rs2_o       <= instr.r.rs2;
        de_rd_o        <= instr.r.rd;
        de_branch_ne_o <= branch_ne;
        de_use_imm_o   <= use_imm;
    end

endmodule

// ==== verilog/execute.sv ====
// execute stage with write-back register
`timescale 1ns/1ps

module execute
    import rv_pipe_pkg::*;
(
    input  logic                clk_i,
    input  logic                arst_n_i,
    input  logic                de_valid_i,
    input  logic [31:0]         de_pc_i,
    input  logic [ALU_OP_W-1:0] de_alu_op_i,
    input  logic [31:0]         de_op_a_i,
    input  logic [31:0]         de_op_b_i,
    input  logic [31:0]         de_imm_i,
    input  logic [4:0]          de_rd_i,
    input  logic                de_we_i,
    input  logic                de_is_branch_i,
    input  logic                de_branch_ne_i,
    input  logic                de_is_jal_i,
    input  logic                de_use_imm_i,
    input  logic                de_illegal_i,
    input  logic                fwd_a_sel_i,
    input  logic                fwd_b_sel_i,
    output logic                redirect_valid_o,
    output logic [31:0]         redirect_pc_o,
    output logic                wb_we_o,
    output logic [4:0]          wb_rd_o,
    output logic [31:0]         wb_data_o,
    output logic                retire_valid_o,
    output logic [31:0]         retire_pc_o,
    output logic                retire_we_o,
    output logic [4:0]          retire_rd_o,
    output logic [31:0]         retire_data_o,
    output logic                retire_illegal_o
);

    logic [31:0] opa;
    logic [31:0] opb;
    logic [31:0] alu_b;
    logic [31:0] alu_res;
    logic        taken;

    assign opa   = (fwd_a_sel_i == FWD_WB) ? wb_data_o : de_op_a_i;
    assign opb   = (fwd_b_sel_i == FWD_WB) ? wb_data_o : de_op_b_i;
    assign alu_b = de_use_imm_i ? de_imm_i : opb;

    always_comb begin
        case (de_alu_op_i)
            ALU_SUB:    alu_res = opa - alu_b;
            ALU_AND:    alu_res = opa & alu_b;
            ALU_OR:     alu_res = opa | alu_b;
            ALU_XOR:    alu_res = opa ^ alu_b;
            ALU_PASS_B: alu_res = alu_b;
            default:    alu_res = opa + alu_b;
        endcase
    end

    // beq on equal, bne on not equal
    assign taken = de_is_jal_i || (de_is_branch_i && ((opa == opb) != de_branch_ne_i));

    assign redirect_valid_o = de_valid_i && taken;
    assign redirect_pc_o    = de_pc_i + de_imm_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            retire_valid_o   <= 1'b0;
            wb_we_o          <= 1'b0;
            retire_illegal_o <= 1'b0;
        end else begin
            retire_valid_o   <= de_valid_i;
            wb_we_o          <= de_valid_i && de_we_i;
            retire_illegal_o <= de_valid_i && de_illegal_i;
        end
    end

    always_ff @(posedge clk_i) begin
        retire_pc_o <= de_pc_i;
        wb_rd_o     <= de_rd_i;
        wb_data_o   <= de_is_jal_i ? de_pc_i + 32'd4 : alu_res; // link value for jal.
    end

    assign retire_we_o   = wb_we_o;
    assign retire_rd_o   = wb_rd_o;
    assign retire_data_o = wb_data_o;

endmodule

// ==== verilog/hazard_control.sv ====
// forwarding and flush control
`timescale 1ns/1ps

module hazard_control
    import rv_pipe_pkg::*;
(
    input  logic       de_valid_i,
    input  logic [4:0] de_rs1_i,
    input  logic [4:0] de_rs2_i,
    input  logic       wb_we_i,
    input  logic [4:0] wb_rd_i,
    input  logic       redirect_valid_i,
    output logic       fwd_a_sel_o,
    output logic       fwd_b_sel_o,
    output logic       flush_o
);

    logic wb_live;

    // x0 never forwards.
    assign wb_live = de_valid_i && wb_we_i && (wb_rd_i != 5'd0);

    always_comb begin
        fwd_a_sel_o = FWD_REG;
        fwd_b_sel_o = FWD_REG;
        if (wb_live && wb_rd_i == de_rs1_i) begin
            fwd_a_sel_o = FWD_WB;
        end
        if (wb_live && wb_rd_i == de_rs2_i) begin
            fwd_b_sel_o = FWD_WB;
        end
    end

    // older stages hold wrong-path words after a redirect
    assign flush_o = redirect_valid_i;

endmodule

// ==== verilog/core_top.sv ====
// three-stage RV32 core
`timescale 1ns/1ps

module core_top
    import rv_pipe_pkg::*;
(
    input  logic        clk_i,
    input  logic        arst_n_i,
    input  logic        imem_wait_i,
    input  logic [31:0] imem_data_i,
    output logic        imem_cs_n_o,
    output logic [31:0] imem_addr_o,
    output logic        retire_valid_o,
    output logic [31:0] retire_pc_o,
    output logic        retire_we_o,
    output logic [4:0]  retire_rd_o,
    output logic [31:0] retire_data_o,
    output logic        retire_illegal_o
);

    logic                fd_valid;
    logic [31:0]         fd_instr;
    logic [31:0]         fd_pc;
    logic                de_valid;
    logic [31:0]         de_pc;
    logic [ALU_OP_W-1:0] de_alu_op;
    logic [31:0]         de_op_a;
    logic [31:0]         de_op_b;
    logic [31:0]         de_imm;
    logic [4:0]          de_rs1;
    logic [4:0]          de_rs2;
    logic [4:0]          de_rd;
    logic                de_we;
    logic                de_is_branch;
    logic                de_branch_ne;
    logic                de_is_jal;
    logic                de_use_imm;
    logic                de_illegal;
    logic                wb_we;
    logic [4:0]          wb_rd;
    logic [31:0]         wb_data;
    logic                redirect_valid;
    logic [31:0]         redirect_pc;
    logic                fwd_a_sel;
    logic                fwd_b_sel;
    logic                flush;

    fetch u_fetch (
        .clk_i(clk_i), .arst_n_i(arst_n_i),
        .imem_wait_i(imem_wait_i), .imem_data_i(imem_data_i),
        .redirect_valid_i(redirect_valid), .redirect_pc_i(redirect_pc),
        .flush_i(flush),
        .imem_cs_n_o(imem_cs_n_o), .imem_addr_o(imem_addr_o),
        .fd_valid_o(fd_valid), .fd_instr_o(fd_instr), .fd_pc_o(fd_pc)
    );

    decode_regread u_decode_regread (
        .clk_i(clk_i), .arst_n_i(arst_n_i),
        .fd_valid_i(fd_valid), .fd_instr_i(fd_instr), .fd_pc_i(fd_pc),
        .flush_i(flush),
        .wb_we_i(wb_we), .wb_rd_i(wb_rd), .wb_data_i(wb_data),
        .de_valid_o(de_valid), .de_pc_o(de_pc), .de_alu_op_o(de_alu_op),
        .de_op_a_o(de_op_a), .de_op_b_o(de_op_b), .de_imm_o(de_imm),
        .de_rs1_o(de_rs1), .de_rs2_o(de_rs2), .de_rd_o(de_rd), .de_we_o(de_we),
        .de_is_branch_o(de_is_branch), .de_branch_ne_o(de_branch_ne),
        .de_is_jal_o(de_is_jal), .de_use_imm_o(de_use_imm),
        .de_illegal_o(de_illegal)
    );

    execute u_execute (
        .clk_i(clk_i), .arst_n_i(arst_n_i),
        .de_valid_i(de_valid), .de_pc_i(de_pc), .de_alu_op_i(de_alu_op),
        .de_op_a_i(de_op_a), .de_op_b_i(de_op_b), .de_imm_i(de_imm),
        .de_rd_i(de_rd), .de_we_i(de_we),
        .de_is_branch_i(de_is_branch), .de_branch_ne_i(de_branch_ne),
        .de_is_jal_i(de_is_jal), .de_use_imm_i(de_use_imm),
        .de_illegal_i(de_illegal),
        .fwd_a_sel_i(fwd_a_sel), .fwd_b_sel_i(fwd_b_sel),
        .redirect_valid_o(redirect_valid), .redirect_pc_o(redirect_pc),
        .wb_we_o(wb_we), .wb_rd_o(wb_rd), .wb_data_o(wb_data),
        .retire_valid_o(retire_valid_o), .retire_pc_o(retire_pc_o),
        .retire_we_o(retire_we_o), .retire_rd_o(retire_rd_o),
        .retire_data_o(retire_data_o), .retire_illegal_o(retire_illegal_o)
    );

    hazard_control u_hazard_control (
        .de_valid_i(de_valid), .de_rs1_i(de_rs1), .de_rs2_i(de_rs2),
        .wb_we_i(wb_we), .wb_rd_i(wb_rd),
        .redirect_valid_i(redirect_valid),
        .fwd_a_sel_o(fwd_a_sel), .fwd_b_sel_o(fwd_b_sel), .flush_o(flush)
    );

endmodule

// ==== bench/tb_clock.sv ====
// testbench clock source
`timescale 1ns/1ps

module tb_clock (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #20 clk_o = ~clk_o; // 40 ns period.
        end
    end

endmodule

// ==== bench/core_asserts.sv ====
// core interface assertions
`timescale 1ns/1ps

module core_asserts (
    input logic        clk_i,
    input logic        arst_n_i,
    input logic        wait_i,
    input logic        cs_n_i,
    input logic [31:0] addr_i,
    input logic        redirect_i,
    input logic        retire_we_i,
    input logic [4:0]  retire_rd_i
);

    cs_idle_in_reset: assert property (@(posedge clk_i) !arst_n_i |-> cs_n_i)
        else $error("instruction request active during reset");

    // a redirect may replace the pending address
    addr_held_in_wait: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (!cs_n_i && wait_i && !redirect_i) |=> $stable(addr_i))
        else $error("fetch address changed while the memory was waiting");

    no_write_to_x0: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        retire_we_i |-> (retire_rd_i != 5'd0))
        else $error("retired write targets x0");

endmodule

bind core_top core_asserts u_core_asserts (
    .clk_i(clk_i), .arst_n_i(arst_n_i), .wait_i(imem_wait_i),
    .cs_n_i(imem_cs_n_o), .addr_i(imem_addr_o), .redirect_i(redirect_valid),
    .retire_we_i(retire_we_o), .retire_rd_i(retire_rd_o)
);

// ==== bench/core_tb.sv ====
// RV32 core testbench
`timescale 1ns/1ps

module core_tb
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
();

    logic        clk;
    logic        arst_n;
    logic        imem_wait;
    logic [31:0] imem_data;
    logic        imem_cs_n;
    logic [31:0] imem_addr;
    logic        retire_valid;
    logic [31:0] retire_pc;
    logic        retire_we;
    logic [4:0]  retire_rd;
    logic [31:0] retire_data;
    logic        retire_illegal;

    logic [31:0] mem [64];
    logic [31:0] xreg [32];
    logic [31:0] exp_pc [$];
    logic        exp_we [$];
    logic [4:0]  exp_rd [$];
    logic [31:0] exp_data [$];
    logic        exp_ill [$];
    logic        exp_redir [$];
    integer      seed = 32'h5e13_04f1;
    int          prog_len;
    int          cur_idx;
    int          errors;
    int          n_tests;
    int          n_failed;

    tb_clock u_clock (.clk_o(clk));

    core_top u_core_top (
        .clk_i(clk), .arst_n_i(arst_n),
        .imem_wait_i(imem_wait), .imem_data_i(imem_data),
        .imem_cs_n_o(imem_cs_n), .imem_addr_o(imem_addr),
        .retire_valid_o(retire_valid), .retire_pc_o(retire_pc),
        .retire_we_o(retire_we), .retire_rd_o(retire_rd),
        .retire_data_o(retire_data), .retire_illegal_o(retire_illegal)
    );

    assign imem_data = mem[imem_addr[7:2]]; // combinational read port.

    function automatic logic [31:0] rr_word(input logic [6:0] f7, input logic [2:0] f3,
                                            input int rd, input int rs1, input int rs2);
        rv_instr_u w;
        w.r.funct7 = f7;
        w.r.rs2    = rs2[4:0];
        w.r.rs1    = rs1[4:0];
        w.r.funct3 = f3;
        w.r.rd     = rd[4:0];
        w.r.opcode = OPC_OP;
        return w;
    endfunction

    function automatic logic [31:0] addi_word(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], F3_ADD_SUB, rd[4:0], OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] lui_word(input int rd, input int imm);
        return {imm[19:0], rd[4:0], OPC_LUI};
    endfunction

    function automatic logic [31:0] branch_word(input logic [2:0] f3, input int rs1,
                                                input int rs2, input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] jal_word(input int rd, input int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], OPC_JAL};
    endfunction

    task automatic fill_memory();
        int i;
        for (i = 0; i < 64; i++) begin
            mem[i[5:0]] = {i[24:0], 7'h00}; // opcode 0 is illegal.
        end
        prog_len = 0;
    endtask

    task automatic emit(input logic [31:0] word);
        mem[prog_len[5:0]] = word;
        prog_len++;
    endtask

    // in-order model of the program, stops at the self-loop jump
    task automatic predict();
        rv_instr_u   w;
        logic [31:0] raw;
        logic [31:0] pc;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] nxt;
        logic        wr;
        logic        ill;
        logic        taken;
        int          step;
        pc = RESET_PC;
        exp_pc.delete();
        exp_we.delete();
        exp_rd.delete();
        exp_data.delete();
        exp_ill.delete();
        exp_redir.delete();
        for (step = 0; step < 64; step++) begin
            raw   = mem[pc[7:2]];
            w     = raw;
            a     = xreg[w.r.rs1];
            b     = xreg[w.r.rs2];
            res   = 32'd0;
            wr    = 1'b1;
            ill   = 1'b0;
            taken = 1'b0;
            nxt   = pc + 32'd4;
            case (w.r.opcode)
                OPC_OP: begin
                    case ({w.r.funct7, w.r.funct3})
                        {7'h00, F3_ADD_SUB}: res = a + b;
                        {F7_SUB, F3_ADD_SUB}: res = a - b;
                        {7'h00, F3_XOR}: res = a ^ b;
                        {7'h00, F3_OR}: res = a | b;
                        {7'h00, F3_AND}: res = a & b;
                        default: ill = 1'b1;
                    endcase
                end
                OPC_OP_IMM: begin
                    res = a + {{20{raw[31]}}, raw[31:20]};
                    ill = (w.i.funct3 != F3_ADD_SUB);
                end
                OPC_LUI: res = {raw[31:12], 12'd0};
                OPC_BRANCH: begin
                    wr    = 1'b0;
                    ill   = (w.b.funct3 != F3_BEQ) && (w.b.funct3 != F3_BNE);
                    taken = !ill && ((a == b) == (w.b.funct3 == F3_BEQ));
                    if (taken) begin
                        nxt = pc + {{20{raw[31]}}, raw[7], raw[30:25], raw[11:8], 1'b0};
                    end
                end
                OPC_JAL: begin
                    res   = pc + 32'd4; // link value.
                    taken = 1'b1;
                    nxt   = pc + {{12{raw[31]}}, raw[19:12], raw[20], raw[30:21], 1'b0};
                end
                default: ill = 1'b1;
            endcase
            wr = wr && !ill && (w.r.rd != 5'd0);
            exp_pc.push_back(pc);
            exp_we.push_back(wr);
            exp_rd.push_back(w.r.rd);
            exp_data.push_back(res);
            exp_ill.push_back(ill);
            exp_redir.push_back(taken);
            if (wr) begin
                xreg[w.r.rd] = res;
            end
            if (nxt == pc) begin
                break;
            end
            pc = nxt;
        end
    endtask

    task automatic data_compare(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s retire %0d: got 0x%08h expected 0x%08h",
                     name, cur_idx, got, exp);
            errors++;
        end
    endtask

    task automatic index_compare(input string name, input logic [4:0] got,
                                 input logic [4:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s retire %0d: got 0x%02h expected 0x%02h",
                     name, cur_idx, got, exp);
            errors++;
        end
    endtask

    task automatic flag_compare(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH %s retire %0d: got 0x%0h expected 0x%0h",
                     name, cur_idx, got, exp);
            errors++;
        end
    endtask

    task automatic pc_compare(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s retire %0d: got 0x%08h expected 0x%08h",
                     name, cur_idx, got, exp);
            errors++;
        end
    endtask

    // resets the core, then checks every retire against the model
    task automatic run_program(input string name, input int wait_pct);
        int errors_before;
        int gap;
        int want_gap;
        errors_before = errors;
        predict();
        imem_wait = 1'b0;
        arst_n    = 1'b0;
        repeat (10) @(negedge clk);
        arst_n  = 1'b1;
        cur_idx = 0;
        gap     = 0;
        while (cur_idx < exp_pc.size()) begin
            @(negedge clk);
            gap++;
            flag_compare("imem_cs_n_o", imem_cs_n, 1'b0); // request stays on after reset.
            if (retire_valid) begin
                pc_compare("retire_pc_o", retire_pc, exp_pc[cur_idx]);
                flag_compare("retire_we_o", retire_we, exp_we[cur_idx]);
                flag_compare("retire_illegal_o", retire_illegal, exp_ill[cur_idx]);
                if (exp_we[cur_idx]) begin
                    index_compare("retire_rd_o", retire_rd, exp_rd[cur_idx]);
                    data_compare("retire_data_o", retire_data, exp_data[cur_idx]);
                end
                want_gap = (cur_idx > 0 && exp_redir[cur_idx - 1]) ? 3 : 1; // two bubbles.
                if (wait_pct == 0 && cur_idx > 0 && gap != want_gap) begin
                    $display("retire %0d came %0d cycles after the previous one, not %0d",
                             cur_idx, gap, want_gap);
                    errors++;
                end
                gap = 0;
                cur_idx++;
            end
            imem_wait = (wait_pct != 0) && ($unsigned($random(seed)) % 100 < wait_pct);
        end
        n_tests++;
        if (errors != errors_before) begin
            n_failed++;
        end
        $display("test %s: %0d retires, %0d errors", name, exp_pc.size(),
                 errors - errors_before);
    endtask

    task automatic arith_program();
        fill_memory();
        emit(lui_word(1, 'h12345));
        emit(addi_word(1, 1, 'h678));
        emit(addi_word(2, 0, -1));
        emit(lui_word(3, 'ha5a5a));
        emit(addi_word(3, 3, 'h5a5));
        emit(rr_word(7'h00, F3_ADD_SUB, 4, 1, 2));
        emit(rr_word(F7_SUB, F3_ADD_SUB, 5, 1, 3));
        emit(rr_word(7'h00, F3_AND, 6, 1, 3));
        emit(rr_word(7'h00, F3_OR, 7, 1, 3));
        emit(rr_word(7'h00, F3_XOR, 8, 2, 3));
        emit(jal_word(0, 0));
    endtask

    task automatic branch_program();
        fill_memory();
        emit(addi_word(1, 0, 5));
        emit(addi_word(2, 0, 5));
        emit(branch_word(F3_BEQ, 1, 2, 8)); // taken.
        emit(addi_word(3, 0, 1));
        emit(branch_word(F3_BNE, 1, 2, 8));
        emit(addi_word(4, 0, 2));
        emit(branch_word(F3_BNE, 1, 4, 8)); // taken.
        emit(addi_word(5, 0, 3));
        emit(branch_word(F3_BEQ, 1, 4, 8));
        emit(jal_word(6, 8));
        emit(addi_word(7, 0, 4));
        emit(rr_word(7'h00, F3_ADD_SUB, 8, 6, 1)); // uses the link value.
        emit(jal_word(0, 0));
    endtask

    task automatic arith_test();
        arith_program();
        run_program("arith", 0);
    endtask

    // distance 1 forwards, distance 2 uses write-through
    task automatic dependence_test();
        fill_memory();
        emit(addi_word(10, 0, 7));
        emit(addi_word(11, 10, 5));
        emit(addi_word(12, 10, 9));
        emit(addi_word(13, 10, 11));
        emit(rr_word(7'h00, F3_ADD_SUB, 14, 11, 12));
        emit(rr_word(F7_SUB, F3_ADD_SUB, 15, 14, 13));
        emit(rr_word(7'h00, F3_XOR, 16, 14, 15));
        emit(rr_word(7'h00, F3_OR, 17, 16, 14));
        emit(jal_word(0, 0));
        run_program("dependences", 0);
    endtask

    task automatic branch_test();
        branch_program();
        run_program("branches", 0);
    endtask

    task automatic wait_test();
        arith_program();
        run_program("waits_arith", 40);
        branch_program();
        run_program("waits_branch", 40);
    endtask

    task automatic illegal_x0_test();
        fill_memory();
        emit(addi_word(0, 0, 9));
        emit(rr_word(7'h00, F3_ADD_SUB, 1, 0, 0));
        emit(32'h0000_2083); // load opcode with rd x1.
        emit(addi_word(2, 0, 42));
        emit(32'hffff_ffff);
        emit(rr_word(7'h00, F3_OR, 3, 2, 0));
        emit(lui_word(0, 'hfffff));
        emit(rr_word(7'h00, F3_ADD_SUB, 4, 0, 2));
        emit(rr_word(7'h00, F3_ADD_SUB, 5, 1, 2));
        emit(jal_word(0, 0));
        run_program("illegal_x0", 0);
    endtask

    initial begin : main
        int r;
        arst_n    = 1'b0;
        imem_wait = 1'b0;
        errors    = 0;
        n_tests   = 0;
        n_failed  = 0;
        fill_memory();
        for (r = 0; r < 32; r++) begin
            xreg[r] = 32'd0;
        end
        arith_test();
        dependence_test();
        branch_test();
        wait_test();
        illegal_x0_test();
        $display("tests %0d, failed %0d, errors %0d", n_tests, n_failed, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // 67 instructions over all runs, 10 cycles of 40 ns each
    initial begin : watchdog
        #(67 * 10 * 40);
        $display("watchdog expired before the tests finished");
        $display("** FAIL **");
        $finish;
    end

endmodule

// ==== compile.f ====
verilog/rv_isa_pkg.sv
verilog/rv_pipe_pkg.sv
verilog/fetch.sv
verilog/decode_regread.sv
verilog/execute.sv
verilog/hazard_control.sv
verilog/core_top.sv
bench/tb_clock.sv
bench/core_asserts.sv
bench/core_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module core_tb -f compile.f -o core_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/core_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qxF '** PASS **'; then
    exit 0
fi
exit 1
